// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module tb_axi_wr_xbar

obj_dir/Vtb_axi_wr_xbar: flist.f $(wildcard verilog/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --assert -f flist.f --top-module tb_axi_wr_xbar

sim: obj_dir/Vtb_axi_wr_xbar
	@out="$$(./obj_dir/Vtb_axi_wr_xbar)"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir

// File: flist.f
verilog/axi_wr_pkg.sv
verilog/axi_b_if.sv
verilog/xbar_cfg_regs.sv
verilog/aw_arbiter.sv
verilog/w_channel_router.sv
verilog/write_response_channel.sv
verilog/axi_wr_xbar_top.sv
test/tb_axi_wr_xbar.sv

// File: test/tb_axi_wr_xbar.sv
`default_nettype none

module tb_axi_wr_xbar import axi_wr_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 200;

    logic                                  aclk = 1'b0;
    logic                                  rst_n;
    logic [NUM_MASTERS-1:0]                m_awvalid;
    logic [NUM_MASTERS-1:0]                m_awready;
    logic [NUM_MASTERS-1:0][ADDR_BITS-1:0] m_awaddr;
    logic [NUM_MASTERS-1:0][ID_BITS-1:0]   m_awid;
    logic [NUM_MASTERS-1:0]                m_wvalid;
    logic [NUM_MASTERS-1:0]                m_wready;
    logic [NUM_MASTERS-1:0][DATA_BITS-1:0] m_wdata;
    logic [NUM_MASTERS-1:0]                m_bvalid;
    logic [NUM_MASTERS-1:0]                m_bready;
    logic [NUM_MASTERS-1:0][ID_BITS-1:0]   m_bid;
    logic [NUM_MASTERS-1:0][1:0]           m_bresp;
    logic [NUM_SLAVES-1:0]                 s_awvalid;
    logic [NUM_SLAVES-1:0]                 s_awready;
    logic [NUM_SLAVES-1:0][ADDR_BITS-1:0]  s_awaddr;
    logic [NUM_SLAVES-1:0][IDS_BITS-1:0]   s_awid;
    logic [NUM_SLAVES-1:0]                 s_wvalid;
    logic [NUM_SLAVES-1:0]                 s_wready;
    logic [NUM_SLAVES-1:0][DATA_BITS-1:0]  s_wdata;
    logic [NUM_SLAVES-1:0]                 s_bvalid;
    logic [NUM_SLAVES-1:0]                 s_bready;
    logic [NUM_SLAVES-1:0][IDS_BITS-1:0]   s_bid;
    logic [NUM_SLAVES-1:0][1:0]            s_bresp;
    logic                                  cfg_we;
    logic [CFG_ADDR_BITS-1:0]              cfg_addr;
    logic [CFG_DATA_BITS-1:0]              cfg_wdata;
    logic [CFG_DATA_BITS-1:0]              cfg_rdata;

    // What each slave model last received
    logic [ADDR_BITS-1:0] got_addr [NUM_SLAVES];
    logic [IDS_BITS-1:0]  got_id   [NUM_SLAVES];
    logic [DATA_BITS-1:0] got_data [NUM_SLAVES];
    int                   valid_cycles [NUM_SLAVES];
    int                   finish_order [$];
    int                   errors = 0;
    int                   timeouts = 0;

    axi_wr_xbar_top uut (.*);

    always #10 aclk = ~aclk;

    // Slave models, random accept delay, B right after the W beat
    for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slave
        int                  phase = 0;
        int                  delay = 0;
        logic                aw_rdy = 1'b0;
        logic                w_rdy = 1'b0;
        logic                b_vld = 1'b0;
        logic [IDS_BITS-1:0] b_id = '0;

        assign s_awready[s] = aw_rdy;
        assign s_wready[s]  = w_rdy;
        assign s_bvalid[s]  = b_vld;
        assign s_bid[s]     = b_id;
        assign s_bresp[s]   = (s == 3) ? RESP_SLVERR : RESP_OKAY;

        always @(posedge aclk or negedge rst_n) begin
            if (!rst_n) begin
                phase  <= 0;
                delay  <= 0;
                aw_rdy <= 1'b0;
                w_rdy  <= 1'b0;
                b_vld  <= 1'b0;
            end else begin
                if (s_awvalid[s] || s_wvalid[s]) valid_cycles[s] <= valid_cycles[s] + 1;
                case (phase)
                    0: if (aw_rdy && s_awvalid[s]) begin
                        aw_rdy      <= 1'b0;
                        got_addr[s] <= s_awaddr[s];
                        got_id[s]   <= s_awid[s];
                        b_id        <= s_awid[s];
                        delay       <= $urandom % 4;
                        phase       <= 1;
                    end else if (s_awvalid[s]) begin
                        if (delay == 0) aw_rdy <= 1'b1;
                        else delay <= delay - 1;
                    end
                    1: if (w_rdy && s_wvalid[s]) begin
                        w_rdy       <= 1'b0;
                        got_data[s] <= s_wdata[s];
                        b_vld       <= 1'b1;
                        phase       <= 2;
                    end else if (s_wvalid[s]) begin
                        if (delay == 0) w_rdy <= 1'b1;
                        else delay <= delay - 1;
                    end
                    default: if (b_vld && s_bready[s]) begin
                        b_vld <= 1'b0;
                        delay <= $urandom % 4;
                        phase <= 0;
                    end
                endcase
            end
        end
    end

    function automatic void check_value(input string name, input logic [31:0] got,
                                        input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endfunction

    task automatic cfg_write(input logic [CFG_ADDR_BITS-1:0] a,
                             input logic [CFG_DATA_BITS-1:0] d);
        @(posedge aclk);
        cfg_we    <= 1'b1;
        cfg_addr  <= a;
        cfg_wdata <= d;
        @(posedge aclk);
        cfg_we    <= 1'b0;
    endtask

    task automatic cfg_readback(input logic [CFG_ADDR_BITS-1:0] a,
                                input logic [CFG_DATA_BITS-1:0] exp);
        @(posedge aclk);
        cfg_addr <= a;
        @(negedge aclk);
        check_value("cfg_rdata", 32'(cfg_rdata), 32'(exp));
    endtask

    // One single beat write; bready held low for hold_b cycles of bvalid
    task automatic master_write(input int m, input logic [ADDR_BITS-1:0] addr,
                                input logic [ID_BITS-1:0] id, input logic [DATA_BITS-1:0] data,
                                input logic [1:0] exp_resp, input int hold_b);
        int                 cycles = 0;
        int                 held = 0;
        bit                 aw_hs;
        bit                 w_hs;
        bit                 b_hs = 1'b0;
        bit                 bv_seen = 1'b0;
        logic [ID_BITS-1:0] bid0 = '0;
        logic [1:0]         bresp0 = '0;
        @(posedge aclk);
        m_awvalid[m] <= 1'b1;
        m_awaddr[m]  <= addr;
        m_awid[m]    <= id;
        m_wvalid[m]  <= 1'b1;
        m_wdata[m]   <= data;
        m_bready[m]  <= (hold_b == 0);
        while (!b_hs && cycles < TIMEOUT_CYCLES) begin
            @(negedge aclk);
            cycles++;
            aw_hs = m_awvalid[m] && m_awready[m];
            w_hs  = m_wvalid[m] && m_wready[m];
            if (bv_seen) begin
                assert (m_bvalid[m] && m_bid[m] == bid0 && m_bresp[m] == bresp0) else begin
                    errors++;
                    $display("master %0d B response changed before its handshake", m);
                end
            end
            if (m_bvalid[m]) begin
                bv_seen = 1'b1;
                bid0    = m_bid[m];
                bresp0  = m_bresp[m];
                if (m_bready[m]) b_hs = 1'b1;
                else held++;
            end
            @(posedge aclk);
            if (aw_hs) m_awvalid[m] <= 1'b0;
            if (w_hs) m_wvalid[m] <= 1'b0;
            m_bready[m] <= !b_hs && held >= hold_b;
        end
        if (!b_hs) begin
            timeouts++;
            $display("master %0d got no write response for address %h in time", m, addr);
            m_awvalid[m] <= 1'b0;
            m_wvalid[m]  <= 1'b0;
            m_bready[m]  <= 1'b0;
        end else begin
            finish_order.push_back(m);
            check_value("m_bid", 32'(bid0), 32'(id));
            check_value("m_bresp", 32'(bresp0), 32'(exp_resp));
        end
    endtask

    task automatic write_and_verify(input int m, input int s);
        logic [ADDR_BITS-1:0] addr;
        logic [ID_BITS-1:0]   id;
        logic [DATA_BITS-1:0] data;
        addr = {s[1:0], 14'(256 * m + 16 * s + 4)};
        id   = 4'(8 * m + s + 3);
        data = $urandom;
        master_write(m, addr, id, data, (s == 3) ? RESP_SLVERR : RESP_OKAY, 0);
        check_value("s_awaddr", 32'(got_addr[s]), 32'(addr));
        check_value("s_awid", 32'(got_id[s]), 32'({m[0], id}));
        check_value("s_wdata", got_data[s], data);
    endtask

    task automatic reset_outputs_low();
        @(negedge aclk);
        check_value("m_awready", 32'(m_awready), 0);
        check_value("m_wready", 32'(m_wready), 0);
        check_value("m_bvalid", 32'(m_bvalid), 0);
        check_value("s_awvalid", 32'(s_awvalid), 0);
        check_value("s_wvalid", 32'(s_wvalid), 0);
        check_value("s_bready", 32'(s_bready), 0);
        cfg_readback(CFG_REG_MASK, 8'h0F);
        cfg_readback(CFG_REG_PRIO, 8'h00);
    endtask

    task automatic route_all_slaves();
        for (int m = 0; m < NUM_MASTERS; m++) begin
            for (int s = 0; s < NUM_SLAVES; s++) write_and_verify(m, s);
        end
    endtask

    // Both masters raise AW in the same cycle
    task automatic tie_break_order();
        for (int p = 0; p < 2; p++) begin
            if (p == 1) cfg_write(CFG_REG_PRIO, 8'(p));
            cfg_readback(CFG_REG_PRIO, 8'(p));
            finish_order.delete();
            fork
                master_write(0, 16'h0040, 4'h1, $urandom, RESP_OKAY, 0);
                master_write(1, 16'h4080, 4'h2, $urandom, RESP_OKAY, 0);
            join
            check_value("first master", finish_order[0], p);
        end
        cfg_write(CFG_REG_PRIO, 8'h00);
    endtask

    task automatic decode_error_write();
        int seen;
        cfg_write(CFG_REG_MASK, 8'h0B);
        cfg_readback(CFG_REG_MASK, 8'h0B);
        seen = valid_cycles[2];
        master_write(1, 16'h8010, 4'h9, $urandom, RESP_DECERR, 0);
        assert (valid_cycles[2] == seen) else begin
            errors++;
            $display("disabled slave 2 saw a valid on AW or W");
        end
        cfg_write(CFG_REG_MASK, 8'h0F);
        write_and_verify(1, 2);
    endtask

    task automatic response_backpressure();
        int hold;
        int cycles = 0;
        hold = 2 + int'($urandom % 6);
        finish_order.delete();
        fork
            master_write(0, 16'h4100, 4'h5, $urandom, RESP_OKAY, hold);
            begin
                repeat (2) @(posedge aclk);
                master_write(1, 16'h0200, 4'h6, $urandom, RESP_OKAY, 0);
            end
            // Master 1 must stay off every slave until master 0 is done
            while (finish_order.size() == 0 && cycles < TIMEOUT_CYCLES) begin
                @(negedge aclk);
                cycles++;
                for (int k = 0; k < NUM_SLAVES; k++) begin
                    assert (!(s_awvalid[k] && s_awid[k][IDS_BITS-1])) else begin
                        errors++;
                        $display("master 1 write reached slave %0d before master 0 finished", k);
                    end
                end
            end
        join
        check_value("first master", finish_order[0], 0);
    endtask

    initial begin
        void'($urandom(84));
        rst_n     <= 1'b0;
        m_awvalid <= '0;
        m_awaddr  <= '0;
        m_awid    <= '0;
        m_wvalid  <= '0;
        m_wdata   <= '0;
        m_bready  <= '0;
        cfg_we    <= 1'b0;
        cfg_addr  <= '0;
        cfg_wdata <= '0;
        repeat (10) @(posedge aclk);
        rst_n <= 1'b1;

        reset_outputs_low();
        route_all_slaves();
        tie_break_order();
        decode_error_write();
        response_backpressure();

        repeat (2) @(posedge aclk);
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/aw_arbiter.sv
`default_nettype none

module aw_arbiter import axi_wr_pkg::*; (
    input  logic                                  aclk,
    input  logic                                  rst_n,
    input  logic [NUM_MASTERS-1:0]                m_awvalid,
    input  logic [NUM_MASTERS-1:0][ADDR_BITS-1:0] m_awaddr,
    input  logic [NUM_MASTERS-1:0][ID_BITS-1:0]   m_awid,
    input  logic [NUM_SLAVES-1:0]                 s_awready,
    input  logic [NUM_SLAVES-1:0]                 slave_en,
    input  logic [MIDX_BITS-1:0]                  prio_master,
    input  logic                                  w_done,
    axi_b_if.arbiter                              b,
    output logic [NUM_MASTERS-1:0]                m_awready,
    output logic [NUM_SLAVES-1:0]                 s_awvalid,
    output logic [NUM_SLAVES-1:0][ADDR_BITS-1:0]  s_awaddr,
    output logic [NUM_SLAVES-1:0][IDS_BITS-1:0]   s_awid,
    output route_t                                route,
    output logic [MIDX_BITS-1:0]                  grant_m,
    output logic [SIDX_BITS-1:0]                  grant_s,
    output arb_state_t                            state,
    output logic [ID_BITS-1:0]                    dec_id
);

    logic [MIDX_BITS-1:0] win_m;
    logic [SIDX_BITS-1:0] win_s;
    logic                 aw_done;
    logic                 b_done;

    // Priority master wins a tie, otherwise the lone requester
    always_comb begin
        if (m_awvalid[prio_master]) begin
            win_m = prio_master;
        end else begin
            win_m = ~prio_master;
        end
        win_s = m_awaddr[win_m][SLAVE_SEL_HI:SLAVE_SEL_LO];
    end

    assign aw_done = m_awvalid[grant_m] && m_awready[grant_m];
    assign b_done  = b.bvalid && b.bready;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ARB_IDLE;
            route   <= ROUTE_NONE;
            grant_m <= '0;
            grant_s <= '0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (|m_awvalid) begin
                        grant_m <= win_m;
                        grant_s <= win_s;
                        route   <= slave_en[win_s] ? ROUTE_SLV : ROUTE_DEC;
                        state   <= ARB_ADDR;
                    end
                end
                ARB_ADDR: begin
                    if (aw_done) state <= ARB_DATA;
                end
                ARB_DATA: begin
                    if (w_done) state <= ARB_RESP;
                end
                ARB_RESP: begin
                    if (b_done) begin
                        state <= ARB_IDLE;
                        route <= ROUTE_NONE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // ID for a locally generated DECERR response
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            dec_id <= '0;
        end else if (state == ARB_IDLE && |m_awvalid) begin
            dec_id <= m_awid[win_m];
        end
    end

    // AW forward to the decoded slave, or local accept on decode error
    always_comb begin
        m_awready = '0;
        s_awvalid = '0;
        s_awaddr  = '0;
        s_awid    = '0;
        if (state == ARB_ADDR) begin
            if (route == ROUTE_SLV) begin
                s_awvalid[grant_s] = m_awvalid[grant_m];
                s_awaddr[grant_s]  = m_awaddr[grant_m];
                s_awid[grant_s]    = {grant_m, m_awid[grant_m]};
                m_awready[grant_m] = s_awready[grant_s];
            end else if (route == ROUTE_DEC) begin
                m_awready[grant_m] = 1'b1;
            end
        end
    end

    a_grant_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        state != ARB_IDLE |=> $stable(grant_m) && $stable(grant_s));

    a_resp_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        state == ARB_RESP && !b_done |=> state == ARB_RESP);

endmodule

`default_nettype wire

// File: verilog/axi_b_if.sv
`default_nettype none

// Master side B handshake of the granted path
interface axi_b_if import axi_wr_pkg::*; ();

    logic               bvalid;
    logic               bready;
    logic [ID_BITS-1:0] bid;
    logic [1:0]         bresp;

    // Driven by the B router, bready mirrors the granted master
    modport router (
        output bvalid,
        output bready,
        output bid,
        output bresp
    );

    // Arbiter watches the handshake to release the grant
    modport arbiter (
        input bvalid,
        input bready,
        input bid,
        input bresp
    );

endinterface

`default_nettype wire

// File: verilog/axi_wr_pkg.sv
`default_nettype none

package axi_wr_pkg;

    // Port counts
    localparam int NUM_MASTERS = 2;
    localparam int NUM_SLAVES  = 4;
    localparam int MIDX_BITS   = $clog2(NUM_MASTERS);
    localparam int SIDX_BITS   = $clog2(NUM_SLAVES);

    // Address map, top two bits pick the slave
    localparam int ADDR_BITS    = 16;
    localparam int SLAVE_SEL_HI = 15;
    localparam int SLAVE_SEL_LO = 14;

    // Slave side ID carries the master index on top
    localparam int ID_BITS   = 4;
    localparam int IDS_BITS  = 5;
    localparam int DATA_BITS = 32;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    // Configuration register file
    localparam int             CFG_ADDR_BITS = 1;
    localparam int             CFG_DATA_BITS = 8;
    localparam logic [CFG_ADDR_BITS-1:0] CFG_REG_MASK = 1'b0;
    localparam logic [CFG_ADDR_BITS-1:0] CFG_REG_PRIO = 1'b1;

    typedef enum logic [1:0] {
        ROUTE_NONE,
        ROUTE_DEC,
        ROUTE_SLV
    } route_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ADDR,
        ARB_DATA,
        ARB_RESP
    } arb_state_t;

endpackage

`default_nettype wire

// File: verilog/axi_wr_xbar_top.sv
`default_nettype none

module axi_wr_xbar_top import axi_wr_pkg::*; (
    input  logic                                  aclk,
    input  logic                                  rst_n,
    // Masters
    input  logic [NUM_MASTERS-1:0]                m_awvalid,
    output logic [NUM_MASTERS-1:0]                m_awready,
    input  logic [NUM_MASTERS-1:0][ADDR_BITS-1:0] m_awaddr,
    input  logic [NUM_MASTERS-1:0][ID_BITS-1:0]   m_awid,
    input  logic [NUM_MASTERS-1:0]                m_wvalid,
    output logic [NUM_MASTERS-1:0]                m_wready,
    input  logic [NUM_MASTERS-1:0][DATA_BITS-1:0] m_wdata,
    output logic [NUM_MASTERS-1:0]                m_bvalid,
    input  logic [NUM_MASTERS-1:0]                m_bready,
    output logic [NUM_MASTERS-1:0][ID_BITS-1:0]   m_bid,
    output logic [NUM_MASTERS-1:0][1:0]           m_bresp,
    // Slaves
    output logic [NUM_SLAVES-1:0]                 s_awvalid,
    input  logic [NUM_SLAVES-1:0]                 s_awready,
    output logic [NUM_SLAVES-1:0][ADDR_BITS-1:0]  s_awaddr,
    output logic [NUM_SLAVES-1:0][IDS_BITS-1:0]   s_awid,
    output logic [NUM_SLAVES-1:0]                 s_wvalid,
    input  logic [NUM_SLAVES-1:0]                 s_wready,
    output logic [NUM_SLAVES-1:0][DATA_BITS-1:0]  s_wdata,
    input  logic [NUM_SLAVES-1:0]                 s_bvalid,
    output logic [NUM_SLAVES-1:0]                 s_bready,
    input  logic [NUM_SLAVES-1:0][IDS_BITS-1:0]   s_bid,
    input  logic [NUM_SLAVES-1:0][1:0]            s_bresp,
    // Configuration
    input  logic                                  cfg_we,
    input  logic [CFG_ADDR_BITS-1:0]              cfg_addr,
    input  logic [CFG_DATA_BITS-1:0]              cfg_wdata,
    output logic [CFG_DATA_BITS-1:0]              cfg_rdata
);

    logic [NUM_SLAVES-1:0] slave_en;
    logic [MIDX_BITS-1:0]  prio_master;
    route_t                route;
    logic [MIDX_BITS-1:0]  grant_m;
    logic [SIDX_BITS-1:0]  grant_s;
    arb_state_t            state;
    logic [ID_BITS-1:0]    dec_id;
    logic                  w_done;

    axi_b_if b_bus ();

    xbar_cfg_regs u_cfg (
        .aclk(aclk), .rst_n(rst_n),
        .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
        .cfg_rdata(cfg_rdata), .slave_en(slave_en), .prio_master(prio_master)
    );

    aw_arbiter u_arb (
        .aclk(aclk), .rst_n(rst_n),
        .m_awvalid(m_awvalid), .m_awaddr(m_awaddr), .m_awid(m_awid),
        .s_awready(s_awready), .slave_en(slave_en), .prio_master(prio_master),
        .w_done(w_done), .b(b_bus),
        .m_awready(m_awready), .s_awvalid(s_awvalid), .s_awaddr(s_awaddr),
        .s_awid(s_awid), .route(route), .grant_m(grant_m), .grant_s(grant_s),
        .state(state), .dec_id(dec_id)
    );

    w_channel_router u_w (
        .aclk(aclk), .rst_n(rst_n),
        .route(route), .grant_m(grant_m), .grant_s(grant_s), .state(state),
        .m_wvalid(m_wvalid), .m_wdata(m_wdata), .s_wready(s_wready),
        .m_wready(m_wready), .s_wvalid(s_wvalid), .s_wdata(s_wdata),
        .w_done(w_done)
    );

    write_response_channel u_b (
        .aclk(aclk), .rst_n(rst_n),
        .route(route), .grant_m(grant_m), .grant_s(grant_s), .state(state),
        .dec_id(dec_id), .s_bvalid(s_bvalid), .s_bid(s_bid), .s_bresp(s_bresp),
        .m_bready(m_bready), .s_bready(s_bready), .m_bid(m_bid),
        .m_bresp(m_bresp), .m_bvalid(m_bvalid), .b(b_bus)
    );

endmodule

`default_nettype wire

// File: verilog/w_channel_router.sv
`default_nettype none

module w_channel_router import axi_wr_pkg::*; (
    input  logic                                  aclk,
    input  logic                                  rst_n,
    input  route_t                                route,
    input  logic [MIDX_BITS-1:0]                  grant_m,
    input  logic [SIDX_BITS-1:0]                  grant_s,
    input  arb_state_t                            state,
    input  logic [NUM_MASTERS-1:0]                m_wvalid,
    input  logic [NUM_MASTERS-1:0][DATA_BITS-1:0] m_wdata,
    input  logic [NUM_SLAVES-1:0]                 s_wready,
    output logic [NUM_MASTERS-1:0]                m_wready,
    output logic [NUM_SLAVES-1:0]                 s_wvalid,
    output logic [NUM_SLAVES-1:0][DATA_BITS-1:0]  s_wdata,
    output logic                                  w_done
);

    always_comb begin
        m_wready = '0;
        s_wvalid = '0;
        s_wdata  = '0;
        if (state == ARB_DATA) begin
            if (route == ROUTE_SLV) begin
                s_wvalid[grant_s] = m_wvalid[grant_m];
                s_wdata[grant_s]  = m_wdata[grant_m];
                m_wready[grant_m] = s_wready[grant_s];
            end else if (route == ROUTE_DEC) begin
                // Beat is sunk here
                m_wready[grant_m] = 1'b1;
            end
        end
    end

    assign w_done = m_wvalid[grant_m] && m_wready[grant_m];

    // Only the decoded slave sees the beat, and only in the data phase
    a_w_phase: assert property (@(posedge aclk) disable iff (!rst_n)
        |s_wvalid |-> state == ARB_DATA && route == ROUTE_SLV && $onehot(s_wvalid));

endmodule

`default_nettype wire

// File: verilog/write_response_channel.sv
`default_nettype none

module write_response_channel import axi_wr_pkg::*; (
    input  logic                                 aclk,
    input  logic                                 rst_n,
    input  route_t                               route,
    input  logic [MIDX_BITS-1:0]                 grant_m,
    input  logic [SIDX_BITS-1:0]                 grant_s,
    input  arb_state_t                           state,
    input  logic [ID_BITS-1:0]                   dec_id,
    input  logic [NUM_SLAVES-1:0]                s_bvalid,
    input  logic [NUM_SLAVES-1:0][IDS_BITS-1:0]  s_bid,
    input  logic [NUM_SLAVES-1:0][1:0]           s_bresp,
    input  logic [NUM_MASTERS-1:0]               m_bready,
    output logic [NUM_SLAVES-1:0]                s_bready,
    output logic [NUM_MASTERS-1:0][ID_BITS-1:0]  m_bid,
    output logic [NUM_MASTERS-1:0][1:0]          m_bresp,
    output logic [NUM_MASTERS-1:0]               m_bvalid,
    axi_b_if.router                              b
);

    logic pass_slv;

    assign pass_slv = (state == ARB_RESP) && (route == ROUTE_SLV);

    // Per master B mux, idle masters see ID zero and DECERR
    always_comb begin
        for (int m = 0; m < NUM_MASTERS; m++) begin
            m_bvalid[m] = 1'b0;
            m_bid[m]    = '0;
            m_bresp[m]  = RESP_DECERR;
        end
        s_bready = '0;
        if (state == ARB_RESP) begin
            case (route)
                ROUTE_SLV: begin
                    m_bvalid[grant_m] = s_bvalid[grant_s];
                    // Strip the master index bit
                    m_bid[grant_m]    = s_bid[grant_s][ID_BITS-1:0];
                    m_bresp[grant_m]  = s_bresp[grant_s];
                    s_bready[grant_s] = m_bready[grant_m];
                end
                ROUTE_DEC: begin
                    m_bvalid[grant_m] = 1'b1;
                    m_bid[grant_m]    = dec_id;
                    m_bresp[grant_m]  = RESP_DECERR;
                end
                default: ;
            endcase
        end
    end

    // Granted path for the arbiter
    assign b.bvalid = m_bvalid[grant_m];
    assign b.bready = m_bready[grant_m];
    assign b.bid    = m_bid[grant_m];
    assign b.bresp  = m_bresp[grant_m];

    // Slave must echo the ID the arbiter built
    a_bid_master: assert property (@(posedge aclk) disable iff (!rst_n)
        pass_slv && s_bvalid[grant_s] |-> s_bid[grant_s][IDS_BITS-1] == grant_m);

endmodule

`default_nettype wire

// File: verilog/xbar_cfg_regs.sv
`default_nettype none

module xbar_cfg_regs import axi_wr_pkg::*; (
    input  logic                     aclk,
    input  logic                     rst_n,
    input  logic                     cfg_we,
    input  logic [CFG_ADDR_BITS-1:0] cfg_addr,
    input  logic [CFG_DATA_BITS-1:0] cfg_wdata,
    output logic [CFG_DATA_BITS-1:0] cfg_rdata,
    output logic [NUM_SLAVES-1:0]    slave_en,
    output logic [MIDX_BITS-1:0]     prio_master
);

    // All slaves enabled, master 0 wins ties out of reset
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            slave_en    <= '1;
            prio_master <= '0;
        end else if (cfg_we) begin
            case (cfg_addr)
                CFG_REG_MASK: slave_en    <= cfg_wdata[NUM_SLAVES-1:0];
                CFG_REG_PRIO: prio_master <= cfg_wdata[MIDX_BITS-1:0];
                default: ;
            endcase
        end
    end

    // Readback, zero extended
    always_comb begin
        cfg_rdata = '0;
        case (cfg_addr)
            CFG_REG_MASK: cfg_rdata[NUM_SLAVES-1:0] = slave_en;
            CFG_REG_PRIO: cfg_rdata[MIDX_BITS-1:0]  = prio_master;
            default: ;
        endcase
    end

endmodule

`default_nettype wire
